/* hw/lc4_pkg.sv */
package lc4_pkg;

   typedef logic [15:0] word_t;     // data, pc and instruction words
   typedef logic [2:0]  reg_idx_t;
   typedef logic [2:0]  nzp_t;      // ordered n, z, p

   // one instruction word read through two field layouts
   typedef union packed {
      // register form
      struct packed {
         logic [3:0] opcode;
         reg_idx_t   rd;
         reg_idx_t   rs;
         logic [2:0] sub;           // function select
         reg_idx_t   rt;
      } r;
      // immediate form, const takes its imm9 as i[8:0]
      struct packed {
         logic [3:0] opcode;
         reg_idx_t   rd;
         reg_idx_t   rs;
         logic       imm;           // set for the imm5 variants
         logic [4:0] imm5;
      } i;
   } insn_u;

   localparam word_t RESET_PC = 16'h8200;   // boot address

   // opcodes of the kept instruction groups
   localparam logic [3:0] OP_ARITH = 4'b0001;
   localparam logic [3:0] OP_LOGIC = 4'b0101;
   localparam logic [3:0] OP_CONST = 4'b1001;

   // arith sub codes, mul and div are left out
   localparam logic [2:0] SUB_ADD = 3'b000;
   localparam logic [2:0] SUB_SUB = 3'b010;

   // logic sub codes, not is left out
   localparam logic [2:0] SUB_AND = 3'b000;
   localparam logic [2:0] SUB_OR  = 3'b010;
   localparam logic [2:0] SUB_XOR = 3'b011;

   localparam nzp_t NZP_N = 3'b100;
   localparam nzp_t NZP_Z = 3'b010;
   localparam nzp_t NZP_P = 3'b001;

   localparam int NUM_REGS = 8;

endpackage

/* hw/lc4_fetch.sv */
`timescale 1ns/10ps

module lc4_fetch (
   input  logic           gwe,
   input  logic           i_rst_n,
   input  logic           i_split,       // decode slot b must wait a cycle
   input  lc4_pkg::word_t i_insn_a,      // imem word at pc
   input  lc4_pkg::word_t i_insn_b,      // imem word at pc+1
   output lc4_pkg::word_t o_cur_pc,
   output lc4_pkg::word_t o_d_insn_a,
   output lc4_pkg::word_t o_d_insn_b,
   output lc4_pkg::word_t o_d_pc_a,
   output lc4_pkg::word_t o_d_pc_b,
   output logic           o_d_valid_a,
   output logic           o_d_valid_b
);
   import lc4_pkg::*;

   word_t pc;
   word_t pc_plus_one;
   word_t pc_plus_two;

   assign pc_plus_one = pc + 16'd1;
   assign pc_plus_two = pc + 16'd2;
   assign o_cur_pc    = pc;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc          <= RESET_PC;
         o_d_valid_a <= 1'b0;
         o_d_valid_b <= 1'b0;
      end else if (i_split) begin
         pc          <= pc_plus_one;   // only one new word was taken
         o_d_valid_a <= o_d_valid_b;
         o_d_valid_b <= 1'b1;
      end else begin
         pc          <= pc_plus_two;
         o_d_valid_a <= 1'b1;
         o_d_valid_b <= 1'b1;
      end
   end

   // on a split the held b word becomes the new a, and the word at pc fills b
   always_ff @(posedge gwe) begin
      if (i_split) begin
         o_d_insn_a <= o_d_insn_b;
         o_d_pc_a   <= o_d_pc_b;
         o_d_insn_b <= i_insn_a;
         o_d_pc_b   <= pc;
      end else begin
         o_d_insn_a <= i_insn_a;
         o_d_pc_a   <= pc;
         o_d_insn_b <= i_insn_b;
         o_d_pc_b   <= pc_plus_one;
      end
   end

endmodule

/* hw/lc4_regfile.sv */
`timescale 1ns/10ps

module lc4_regfile (
   input  logic                     gwe,
   input  logic                     i_rst_n,
   input  lc4_pkg::reg_idx_t [3:0]  i_rsel,     // rs_a, rt_a, rs_b, rt_b
   output lc4_pkg::word_t    [3:0]  o_rdata,
   input  logic                     i_we_a,
   input  logic                     i_we_b,
   input  lc4_pkg::reg_idx_t        i_wsel_a,
   input  lc4_pkg::reg_idx_t        i_wsel_b,
   input  lc4_pkg::word_t           i_wdata_a,
   input  lc4_pkg::word_t           i_wdata_b
);
   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int n = 0; n < NUM_REGS; n++) begin
            regs[n] <= '0;
         end
      end else begin
         if (i_we_a) regs[i_wsel_a] <= i_wdata_a;
         if (i_we_b) regs[i_wsel_b] <= i_wdata_b;   // later slot wins a tie
      end
   end

   // write-through so decode sees what writeback is storing this cycle
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         if (i_we_b && (i_wsel_b == i_rsel[k])) begin
            o_rdata[k] = i_wdata_b;
         end else if (i_we_a && (i_wsel_a == i_rsel[k])) begin
            o_rdata[k] = i_wdata_a;
         end else begin
            o_rdata[k] = regs[i_rsel[k]];
         end
      end
   end

endmodule

/* hw/lc4_issue.sv */
`timescale 1ns/10ps

module lc4_issue (
   input  logic                    gwe,
   input  logic                    i_rst_n,
   input  lc4_pkg::word_t          i_d_insn_a,
   input  lc4_pkg::word_t          i_d_insn_b,
   input  lc4_pkg::word_t          i_d_pc_a,
   input  lc4_pkg::word_t          i_d_pc_b,
   input  logic                    i_d_valid_a,
   input  logic                    i_d_valid_b,
   input  lc4_pkg::word_t    [3:0] i_rdata,
   output lc4_pkg::reg_idx_t [3:0] o_rsel,
   output logic                    o_split,
   output lc4_pkg::word_t          o_x_insn_a,
   output lc4_pkg::word_t          o_x_pc_a,
   output lc4_pkg::word_t          o_x_rs_a,
   output lc4_pkg::word_t          o_x_rt_a,
   output lc4_pkg::reg_idx_t       o_x_wsel_a,
   output logic                    o_x_we_a,
   output logic                    o_x_valid_a,
   output lc4_pkg::word_t          o_x_insn_b,
   output lc4_pkg::word_t          o_x_pc_b,
   output lc4_pkg::word_t          o_x_rs_b,
   output lc4_pkg::word_t          o_x_rt_b,
   output lc4_pkg::reg_idx_t       o_x_wsel_b,
   output logic                    o_x_we_b,
   output logic                    o_x_valid_b
);
   import lc4_pkg::*;

   insn_u d_a;
   insn_u d_b;
   logic  we_a;
   logic  we_b;
   logic  dep_rs;
   logic  dep_rt;

   // true for the words this core executes, everything else is a no-op
   function automatic logic is_kept(input insn_u u);
      logic kept;
      case (u.r.opcode)
         OP_ARITH: kept = u.i.imm || (u.r.sub == SUB_ADD) || (u.r.sub == SUB_SUB);
         OP_LOGIC: kept = u.i.imm || (u.r.sub == SUB_AND) || (u.r.sub == SUB_OR) ||
                          (u.r.sub == SUB_XOR);
         OP_CONST: kept = 1'b1;
         default:  kept = 1'b0;
      endcase
      return kept;
   endfunction

   function automatic logic reads_rs(input insn_u u);
      return is_kept(u) && (u.r.opcode != OP_CONST);
   endfunction

   function automatic logic reads_rt(input insn_u u);
      return reads_rs(u) && !u.i.imm;
   endfunction

   assign d_a  = i_d_insn_a;
   assign d_b  = i_d_insn_b;
   assign we_a = i_d_valid_a && is_kept(d_a);
   assign we_b = i_d_valid_b && is_kept(d_b);

   assign o_rsel[0] = d_a.r.rs;
   assign o_rsel[1] = d_a.r.rt;
   assign o_rsel[2] = d_b.r.rs;
   assign o_rsel[3] = d_b.r.rt;

   // b needs a's result, so it cannot issue alongside it
   assign dep_rs  = reads_rs(d_b) && (d_b.r.rs == d_a.r.rd);
   assign dep_rt  = reads_rt(d_b) && (d_b.r.rt == d_a.r.rd);
   assign o_split = we_a && i_d_valid_b && (dep_rs || dep_rt);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         o_x_we_a    <= 1'b0;
         o_x_valid_a <= 1'b0;
         o_x_we_b    <= 1'b0;
         o_x_valid_b <= 1'b0;
      end else begin
         o_x_we_a    <= we_a;
         o_x_valid_a <= i_d_valid_a;
         o_x_we_b    <= we_b && !o_split;          // b goes through again as a
         o_x_valid_b <= i_d_valid_b && !o_split;
      end
   end

   always_ff @(posedge gwe) begin
      o_x_insn_a <= i_d_insn_a;
      o_x_pc_a   <= i_d_pc_a;
      o_x_rs_a   <= i_rdata[0];
      o_x_rt_a   <= i_rdata[1];
      o_x_wsel_a <= d_a.r.rd;
      o_x_insn_b <= i_d_insn_b;
      o_x_pc_b   <= i_d_pc_b;
      o_x_rs_b   <= i_rdata[2];
      o_x_rt_b   <= i_rdata[3];
      o_x_wsel_b <= d_b.r.rd;
   end

endmodule

/* hw/lc4_execute.sv */
`timescale 1ns/10ps

module lc4_execute (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::word_t    i_x_insn_a,
   input  lc4_pkg::word_t    i_x_pc_a,
   input  lc4_pkg::word_t    i_x_rs_a,
   input  lc4_pkg::word_t    i_x_rt_a,
   input  lc4_pkg::reg_idx_t i_x_wsel_a,
   input  logic              i_x_we_a,
   input  logic              i_x_valid_a,
   input  lc4_pkg::word_t    i_x_insn_b,
   input  lc4_pkg::word_t    i_x_pc_b,
   input  lc4_pkg::word_t    i_x_rs_b,
   input  lc4_pkg::word_t    i_x_rt_b,
   input  lc4_pkg::reg_idx_t i_x_wsel_b,
   input  logic              i_x_we_b,
   input  logic              i_x_valid_b,
   output logic              o_wb_we_a,
   output logic              o_wb_we_b,
   output lc4_pkg::reg_idx_t o_wb_wsel_a,
   output lc4_pkg::reg_idx_t o_wb_wsel_b,
   output lc4_pkg::word_t    o_wb_data_a,
   output lc4_pkg::word_t    o_wb_data_b,
   output logic              o_ret_valid_a,
   output logic              o_ret_valid_b,
   output lc4_pkg::word_t    o_ret_pc_a,
   output lc4_pkg::word_t    o_ret_pc_b,
   output lc4_pkg::word_t    o_ret_insn_a,
   output lc4_pkg::word_t    o_ret_insn_b,
   output lc4_pkg::nzp_t     o_ret_nzp_a,
   output lc4_pkg::nzp_t     o_ret_nzp_b
);
   import lc4_pkg::*;

   insn_u u_a;
   insn_u u_b;
   word_t op_rs_a;
   word_t op_rt_a;
   word_t op_rs_b;
   word_t op_rt_b;
   word_t res_a;
   word_t res_b;

   function automatic word_t alu(input insn_u u, input word_t rs, input word_t rt);
      word_t imm5_sx;
      word_t res;
      imm5_sx = {{11{u.i.imm5[4]}}, u.i.imm5};
      res     = '0;
      case (u.r.opcode)
         OP_ARITH: begin
            if (u.i.imm) res = rs + imm5_sx;
            else if (u.r.sub == SUB_SUB) res = rs - rt;
            else res = rs + rt;
         end
         OP_LOGIC: begin
            if (u.i.imm) res = rs & imm5_sx;          // and-immediate
            else if (u.r.sub == SUB_OR) res = rs | rt;
            else if (u.r.sub == SUB_XOR) res = rs ^ rt;
            else res = rs & rt;
         end
         OP_CONST: res = {{7{u.i[8]}}, u.i[8:0]};    // sign-extended imm9
         default:  res = '0;
      endcase
      return res;
   endfunction

   function automatic nzp_t nzp_of(input word_t v);
      if (v == '0) return NZP_Z;
      if (v[15]) return NZP_N;
      return NZP_P;
   endfunction

   assign u_a = i_x_insn_a;
   assign u_b = i_x_insn_b;

   // bypass from writeback, b is younger so it is checked first
   assign op_rs_a = (o_wb_we_b && (o_wb_wsel_b == u_a.r.rs)) ? o_wb_data_b :
                    (o_wb_we_a && (o_wb_wsel_a == u_a.r.rs)) ? o_wb_data_a : i_x_rs_a;
   assign op_rt_a = (o_wb_we_b && (o_wb_wsel_b == u_a.r.rt)) ? o_wb_data_b :
                    (o_wb_we_a && (o_wb_wsel_a == u_a.r.rt)) ? o_wb_data_a : i_x_rt_a;
   assign op_rs_b = (o_wb_we_b && (o_wb_wsel_b == u_b.r.rs)) ? o_wb_data_b :
                    (o_wb_we_a && (o_wb_wsel_a == u_b.r.rs)) ? o_wb_data_a : i_x_rs_b;
   assign op_rt_b = (o_wb_we_b && (o_wb_wsel_b == u_b.r.rt)) ? o_wb_data_b :
                    (o_wb_we_a && (o_wb_wsel_a == u_b.r.rt)) ? o_wb_data_a : i_x_rt_b;

   assign res_a = alu(u_a, op_rs_a, op_rt_a);
   assign res_b = alu(u_b, op_rs_b, op_rt_b);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         o_wb_we_a     <= 1'b0;
         o_wb_we_b     <= 1'b0;
         o_ret_valid_a <= 1'b0;
         o_ret_valid_b <= 1'b0;
      end else begin
         o_wb_we_a     <= i_x_we_a;
         o_wb_we_b     <= i_x_we_b;
         o_ret_valid_a <= i_x_valid_a;
         o_ret_valid_b <= i_x_valid_b;
      end
   end

   // no-op words report zero nzp bits
   always_ff @(posedge gwe) begin
      o_wb_wsel_a  <= i_x_wsel_a;
      o_wb_data_a  <= res_a;
      o_ret_pc_a   <= i_x_pc_a;
      o_ret_insn_a <= i_x_insn_a;
      o_ret_nzp_a  <= i_x_we_a ? nzp_of(res_a) : '0;
      o_wb_wsel_b  <= i_x_wsel_b;
      o_wb_data_b  <= res_b;
      o_ret_pc_b   <= i_x_pc_b;
      o_ret_insn_b <= i_x_insn_b;
      o_ret_nzp_b  <= i_x_we_b ? nzp_of(res_b) : '0;
   end

endmodule

/* hw/lc4_superscalar.sv */
`timescale 1ns/10ps

module lc4_superscalar (
   input  logic              gwe,
   input  logic              i_rst_n,
   input  lc4_pkg::word_t    i_insn_a,
   input  lc4_pkg::word_t    i_insn_b,
   output lc4_pkg::word_t    o_cur_pc,
   output logic              o_wb_we_a,
   output logic              o_wb_we_b,
   output lc4_pkg::reg_idx_t o_wb_wsel_a,
   output lc4_pkg::reg_idx_t o_wb_wsel_b,
   output lc4_pkg::word_t    o_wb_data_a,
   output lc4_pkg::word_t    o_wb_data_b,
   output logic              o_ret_valid_a,
   output logic              o_ret_valid_b,
   output lc4_pkg::word_t    o_ret_pc_a,
   output lc4_pkg::word_t    o_ret_pc_b,
   output lc4_pkg::word_t    o_ret_insn_a,
   output lc4_pkg::word_t    o_ret_insn_b,
   output lc4_pkg::nzp_t     o_ret_nzp_a,
   output lc4_pkg::nzp_t     o_ret_nzp_b
);
   import lc4_pkg::*;

   // decode slots
   word_t d_insn_a, d_insn_b, d_pc_a, d_pc_b;
   logic  d_valid_a, d_valid_b;
   logic  split;

   reg_idx_t [3:0] rsel;
   word_t    [3:0] rdata;

   // execute slots
   word_t    x_insn_a, x_pc_a, x_rs_a, x_rt_a;
   word_t    x_insn_b, x_pc_b, x_rs_b, x_rt_b;
   reg_idx_t x_wsel_a, x_wsel_b;
   logic     x_we_a, x_we_b, x_valid_a, x_valid_b;

   lc4_fetch u_fetch (
      .gwe (gwe), .i_rst_n (i_rst_n), .i_split (split),
      .i_insn_a (i_insn_a), .i_insn_b (i_insn_b), .o_cur_pc (o_cur_pc),
      .o_d_insn_a (d_insn_a), .o_d_insn_b (d_insn_b),
      .o_d_pc_a (d_pc_a), .o_d_pc_b (d_pc_b),
      .o_d_valid_a (d_valid_a), .o_d_valid_b (d_valid_b)
   );

   lc4_issue u_issue (
      .gwe (gwe), .i_rst_n (i_rst_n),
      .i_d_insn_a (d_insn_a), .i_d_insn_b (d_insn_b), .i_d_pc_a (d_pc_a), .i_d_pc_b (d_pc_b),
      .i_d_valid_a (d_valid_a), .i_d_valid_b (d_valid_b),
      .i_rdata (rdata), .o_rsel (rsel), .o_split (split),
      .o_x_insn_a (x_insn_a), .o_x_pc_a (x_pc_a), .o_x_rs_a (x_rs_a), .o_x_rt_a (x_rt_a),
      .o_x_wsel_a (x_wsel_a), .o_x_we_a (x_we_a), .o_x_valid_a (x_valid_a),
      .o_x_insn_b (x_insn_b), .o_x_pc_b (x_pc_b), .o_x_rs_b (x_rs_b), .o_x_rt_b (x_rt_b),
      .o_x_wsel_b (x_wsel_b), .o_x_we_b (x_we_b), .o_x_valid_b (x_valid_b)
   );

   // written from the writeback register, read by decode
   lc4_regfile u_regfile (
      .gwe (gwe), .i_rst_n (i_rst_n), .i_rsel (rsel), .o_rdata (rdata),
      .i_we_a (o_wb_we_a), .i_we_b (o_wb_we_b),
      .i_wsel_a (o_wb_wsel_a), .i_wsel_b (o_wb_wsel_b),
      .i_wdata_a (o_wb_data_a), .i_wdata_b (o_wb_data_b)
   );

   lc4_execute u_execute (
      .gwe (gwe), .i_rst_n (i_rst_n),
      .i_x_insn_a (x_insn_a), .i_x_pc_a (x_pc_a), .i_x_rs_a (x_rs_a), .i_x_rt_a (x_rt_a),
      .i_x_wsel_a (x_wsel_a), .i_x_we_a (x_we_a), .i_x_valid_a (x_valid_a),
      .i_x_insn_b (x_insn_b), .i_x_pc_b (x_pc_b), .i_x_rs_b (x_rs_b), .i_x_rt_b (x_rt_b),
      .i_x_wsel_b (x_wsel_b), .i_x_we_b (x_we_b), .i_x_valid_b (x_valid_b),
      .o_wb_we_a (o_wb_we_a), .o_wb_we_b (o_wb_we_b),
      .o_wb_wsel_a (o_wb_wsel_a), .o_wb_wsel_b (o_wb_wsel_b),
      .o_wb_data_a (o_wb_data_a), .o_wb_data_b (o_wb_data_b),
      .o_ret_valid_a (o_ret_valid_a), .o_ret_valid_b (o_ret_valid_b),
      .o_ret_pc_a (o_ret_pc_a), .o_ret_pc_b (o_ret_pc_b),
      .o_ret_insn_a (o_ret_insn_a), .o_ret_insn_b (o_ret_insn_b),
      .o_ret_nzp_a (o_ret_nzp_a), .o_ret_nzp_b (o_ret_nzp_b)
   );

endmodule

/* dv/lc4_model.svh */
`ifndef LC4_MODEL_SVH
`define LC4_MODEL_SVH

word_t model_regs [NUM_REGS];   // architected registers
word_t model_pc;                // pc of the next instruction to retire

function automatic void model_reset();
   for (int n = 0; n < NUM_REGS; n++) begin
      model_regs[n] = '0;
   end
   model_pc = RESET_PC;
endfunction

// one word in program order, no-ops leave the registers alone
function automatic void model_step(input word_t insn, output logic we, output reg_idx_t rd,
                                   output word_t res, output nzp_t nzp);
   word_t a;
   word_t b;
   word_t simm5;
   a     = model_regs[insn[8:6]];
   b     = model_regs[insn[2:0]];
   simm5 = {{11{insn[4]}}, insn[4:0]};
   rd    = insn[11:9];
   we    = 1'b1;
   res   = '0;
   case (insn[15:12])
      OP_ARITH: begin
         if (insn[5]) res = a + simm5;
         else if (insn[5:3] == SUB_ADD) res = a + b;
         else if (insn[5:3] == SUB_SUB) res = a - b;
         else we = 1'b0;                 // mul, div
      end
      OP_LOGIC: begin
         if (insn[5]) res = a & simm5;
         else if (insn[5:3] == SUB_AND) res = a & b;
         else if (insn[5:3] == SUB_OR) res = a | b;
         else if (insn[5:3] == SUB_XOR) res = a ^ b;
         else we = 1'b0;                 // not
      end
      OP_CONST: res = {{7{insn[8]}}, insn[8:0]};
      default:  we = 1'b0;
   endcase
   if (!we) nzp = 3'b000;
   else if (res == '0) nzp = NZP_Z;
   else if (res[15]) nzp = NZP_N;
   else nzp = NZP_P;
   if (we) model_regs[rd] = res;
   model_pc = model_pc + 16'd1;
endfunction

`endif

/* dv/lc4_tb.sv */
`timescale 1ns/10ps

module lc4_tb;
   import lc4_pkg::*;

   localparam int          PROG_WORDS  = 256;
   localparam logic [31:0] SEED        = 32'h62a6;
   localparam int          NUM_RETIRE  = 2000;
   localparam int          FIRST_LIMIT = 8;   // cycles from reset release to first retirement
   localparam int          IDLE_LIMIT  = 4;

   logic     gwe;
   logic     i_rst_n;
   word_t    i_insn_a;
   word_t    i_insn_b;
   word_t    o_cur_pc;
   logic     o_wb_we_a, o_wb_we_b, o_ret_valid_a, o_ret_valid_b;
   reg_idx_t o_wb_wsel_a, o_wb_wsel_b;
   word_t    o_wb_data_a, o_wb_data_b, o_ret_pc_a, o_ret_pc_b, o_ret_insn_a, o_ret_insn_b;
   nzp_t     o_ret_nzp_a, o_ret_nzp_b;

   word_t       prog [PROG_WORDS];
   logic [31:0] lfsr;
   int          retired;
   int          idle;

   `include "lc4_model.svh"

   lc4_superscalar u_lc4_superscalar (
      .gwe (gwe), .i_rst_n (i_rst_n), .i_insn_a (i_insn_a), .i_insn_b (i_insn_b),
      .o_cur_pc (o_cur_pc),
      .o_wb_we_a (o_wb_we_a), .o_wb_we_b (o_wb_we_b),
      .o_wb_wsel_a (o_wb_wsel_a), .o_wb_wsel_b (o_wb_wsel_b),
      .o_wb_data_a (o_wb_data_a), .o_wb_data_b (o_wb_data_b),
      .o_ret_valid_a (o_ret_valid_a), .o_ret_valid_b (o_ret_valid_b),
      .o_ret_pc_a (o_ret_pc_a), .o_ret_pc_b (o_ret_pc_b),
      .o_ret_insn_a (o_ret_insn_a), .o_ret_insn_b (o_ret_insn_b),
      .o_ret_nzp_a (o_ret_nzp_a), .o_ret_nzp_b (o_ret_nzp_b)
   );

   initial begin
      gwe = 1'b0;
      forever #10 gwe = ~gwe;
   end

   // asynchronous imem, pc only moves at the rising edge
   always @(o_cur_pc) begin
      i_insn_a <= prog[o_cur_pc[7:0]];
      i_insn_b <= prog[8'(o_cur_pc + 16'd1)];
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] v;
      logic        lsb;
      v = '0;
      for (int k = 0; k < nbits; k++) begin
         lsb  = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb) lfsr = lfsr ^ 32'h80200003;
         v = {v[30:0], lsb};
      end
      return v;
   endfunction

   // registers r0..r3 only, so dependences are dense
   function automatic word_t random_insn();
      logic [3:0] kind;
      reg_idx_t   rd;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic [4:0] imm5;
      logic [8:0] imm9;
      word_t      w;
      kind = 4'(lfsr_take(4));
      rd   = reg_idx_t'(lfsr_take(2));
      rs   = reg_idx_t'(lfsr_take(2));
      rt   = reg_idx_t'(lfsr_take(2));
      imm5 = 5'(lfsr_take(5));
      imm9 = 9'(lfsr_take(9));
      case (kind)
         4'd0, 4'd8:  w = {OP_ARITH, rd, rs, SUB_ADD, rt};
         4'd1, 4'd9:  w = {OP_ARITH, rd, rs, SUB_SUB, rt};
         4'd2, 4'd10: w = {OP_ARITH, rd, rs, 1'b1, imm5};
         4'd3, 4'd11: w = {OP_LOGIC, rd, rs, SUB_AND, rt};
         4'd4, 4'd12: w = {OP_LOGIC, rd, rs, SUB_OR, rt};
         4'd5, 4'd13: w = {OP_LOGIC, rd, rs, SUB_XOR, rt};
         4'd6:        w = {OP_LOGIC, rd, rs, 1'b1, imm5};
         4'd7:        w = {OP_CONST, rd, imm9};
         4'd14:       w = '0;
         default: begin
            case (2'(lfsr_take(2)))
               2'd0:    w = {OP_ARITH, rd, rs, 3'b001, rt};   // mul
               2'd1:    w = {OP_ARITH, rd, rs, 3'b011, rt};   // div
               2'd2:    w = {OP_LOGIC, rd, rs, 3'b001, rt};   // not
               default: w = 16'(lfsr_take(16));
            endcase
         end
      endcase
      return w;
   endfunction

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic abort_run(input string why);
      $display("Error at time %0t: %s", $time, why);
      $display("TEST FAIL");
      $fatal(1, "run aborted");
   endtask

   // compares one retirement slot with the next instruction of the model
   task automatic check_slot(input logic slot_b);
      string    sfx;
      word_t    got_pc;
      word_t    got_insn;
      word_t    got_data;
      reg_idx_t got_wsel;
      nzp_t     got_nzp;
      logic     got_we;
      word_t    exp_pc;
      word_t    exp_insn;
      word_t    exp_data;
      reg_idx_t exp_rd;
      nzp_t     exp_nzp;
      logic     exp_we;
      sfx      = slot_b ? "b" : "a";
      got_pc   = slot_b ? o_ret_pc_b : o_ret_pc_a;
      got_insn = slot_b ? o_ret_insn_b : o_ret_insn_a;
      got_data = slot_b ? o_wb_data_b : o_wb_data_a;
      got_wsel = slot_b ? o_wb_wsel_b : o_wb_wsel_a;
      got_nzp  = slot_b ? o_ret_nzp_b : o_ret_nzp_a;
      got_we   = slot_b ? o_wb_we_b : o_wb_we_a;
      exp_pc   = model_pc;
      exp_insn = prog[exp_pc[7:0]];
      model_step(exp_insn, exp_we, exp_rd, exp_data, exp_nzp);
      assert (got_pc == exp_pc) else report_mismatch({"o_ret_pc_", sfx}, got_pc, exp_pc);
      assert (got_insn == exp_insn)
         else report_mismatch({"o_ret_insn_", sfx}, got_insn, exp_insn);
      assert (got_we == exp_we) else report_mismatch({"o_wb_we_", sfx}, got_we, exp_we);
      if (exp_we) begin
         assert (got_wsel == exp_rd)
            else report_mismatch({"o_wb_wsel_", sfx}, got_wsel, exp_rd);
         assert (got_data == exp_data)
            else report_mismatch({"o_wb_data_", sfx}, got_data, exp_data);
      end
      assert (got_nzp == exp_nzp) else report_mismatch({"o_ret_nzp_", sfx}, got_nzp, exp_nzp);
   endtask

   task automatic wait_retirement();
      int n;
      n = 0;
      @(negedge gwe);
      while (!o_ret_valid_a && !o_ret_valid_b && n < IDLE_LIMIT) begin
         @(negedge gwe);
         n++;
      end
      assert (o_ret_valid_a || o_ret_valid_b) else abort_run("timeout waiting for a retirement");
   endtask

   initial begin
      i_rst_n  = 1'b0;
      i_insn_a = '0;
      i_insn_b = '0;
      lfsr     = SEED;
      for (int n = 0; n < PROG_WORDS; n++) begin
         prog[n] = random_insn();
      end
      model_reset();
      repeat (4) @(posedge gwe);
      i_rst_n <= 1'b1;
      @(negedge gwe);
      assert (o_cur_pc == RESET_PC) else report_mismatch("o_cur_pc", o_cur_pc, RESET_PC);
      idle = 0;
      while (!o_ret_valid_a && idle < FIRST_LIMIT) begin
         assert (!o_ret_valid_b && !o_wb_we_a && !o_wb_we_b)
            else abort_run("slot b or a write enable is active before the first retirement");
         @(negedge gwe);
         idle++;
      end
      assert (o_ret_valid_a) else abort_run("timeout waiting for the first retirement");
      assert (o_ret_pc_a == RESET_PC) else report_mismatch("o_ret_pc_a", o_ret_pc_a, RESET_PC);
      retired = 0;
      while (retired < NUM_RETIRE) begin
         if (o_ret_valid_a) begin
            check_slot(1'b0);
            retired++;
         end
         if (o_ret_valid_b) begin
            check_slot(1'b1);   // always younger than slot a
            retired++;
         end
         if (retired < NUM_RETIRE) wait_retirement();
      end
      $display("%0d instructions retired in program order", retired);
      $display("TEST PASS");
      $finish;
   end

endmodule

/* build.f */
+incdir+dv
hw/lc4_pkg.sv
hw/lc4_fetch.sv
hw/lc4_regfile.sv
hw/lc4_issue.sv
hw/lc4_execute.sv
hw/lc4_superscalar.sv
dv/lc4_tb.sv
